// ==== include/csi2_defs.svh ====
`ifndef CSI2_DEFS_SVH
`define CSI2_DEFS_SVH

// width of a PHY word and of a beat's data.
`define CSI2_DATA_W 32

// beats held by each port FIFO, a power of two.
`define CSI2_FIFO_DEPTH 64

// peer ports, the arbiter serves exactly two.
`define CSI2_PORTS 2

`endif

// ==== source/csi2_pkg.sv ====
package csi2_pkg;

  // header class, decided by the data type.
  typedef enum logic {
    DT_SHORT = 1'b0,
    DT_LONG  = 1'b1
  } dt_class_e;

  typedef struct packed {
    logic [7:0]  ecc;
    logic [15:0] wc;
    logic [1:0]  vc;
    logic [5:0]  dt;
  } pkt_hdr_t;

  localparam logic [5:0] DT_LONG_MIN = 6'h10;

  function automatic dt_class_e hdr_class(input pkt_hdr_t hdr);
    dt_class_e cls;
    if (hdr.dt < DT_LONG_MIN)
      cls = DT_SHORT;
    else
      cls = DT_LONG;
    return cls;
  endfunction

endpackage

// ==== source/stream_pkg.sv ====
`include "csi2_defs.svh"

package stream_pkg;

  localparam int STRB_W = `CSI2_DATA_W / 8;
  localparam int PORT_W = $clog2(`CSI2_PORTS);

  // one beat of the merged stream.
  typedef struct packed {
    logic                    valid;
    logic [`CSI2_DATA_W-1:0] data;
    logic [STRB_W-1:0]       strb;
    logic                    last;
    logic                    err;
    logic [PORT_W-1:0]       port;
  } beat_t;

  typedef enum logic [1:0] {
    ARB_IDLE   = 2'd0,
    ARB_SERVE0 = 2'd1,
    ARB_SERVE1 = 2'd2
  } arb_state_e;

endpackage

// ==== source/csi2_packetizer.sv ====
`timescale 1ns/10ps
`include "csi2_defs.svh"

module csi2_packetizer
(
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic [`CSI2_DATA_W-1:0] data_i,
  input  logic                    valid_i,
  input  logic                    err_i,
  output logic                    phy_rst_o,
  output stream_pkg::beat_t       beat_o
);

  localparam int STRB_W = stream_pkg::STRB_W;

  csi2_pkg::pkt_hdr_t hdr;
  stream_pkg::beat_t  beat_nxt;
  logic               valid_d1;
  logic               pkt_running;
  logic               header_valid;
  logic               short_hdr;
  logic               long_hdr;
  logic               last_word;
  logic               err_word;
  logic [16:0]        bytes_left;
  logic [STRB_W-1:0]  last_strb;

  assign hdr = csi2_pkg::pkt_hdr_t'(data_i);

  // a header is the first valid word outside a packet.
  assign header_valid = valid_i && !valid_d1 && !err_i && !pkt_running;
  assign short_hdr    = header_valid && (csi2_pkg::hdr_class(hdr) == csi2_pkg::DT_SHORT);
  assign long_hdr     = header_valid && (csi2_pkg::hdr_class(hdr) == csi2_pkg::DT_LONG);
  assign last_word    = pkt_running && valid_i && (bytes_left <= 17'(STRB_W));
  assign err_word     = pkt_running && err_i;
  assign phy_rst_o    = short_hdr || last_word || err_i;

  // bytes still owed in the last word.
  always_comb
  begin
    for (int i = 0; i < STRB_W; i++)
      last_strb[i] = (i < bytes_left);
  end

  always_comb
  begin
    beat_nxt       = '0;
    beat_nxt.valid = header_valid || (pkt_running && (valid_i || err_i));
    beat_nxt.data  = data_i;
    beat_nxt.strb  = last_word ? last_strb : '1;
    beat_nxt.last  = short_hdr || last_word || err_word;
    beat_nxt.err   = err_word;
  end

  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
      valid_d1 <= 1'b0;
    else
      valid_d1 <= valid_i;
  end

  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
      pkt_running <= 1'b0;
    else if (long_hdr)
      pkt_running <= 1'b1;
    else if (last_word || err_word)
      pkt_running <= 1'b0;
  end

  // payload plus two crc bytes, four per word.
  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
      bytes_left <= '0;
    else if (long_hdr)
      bytes_left <= {1'b0, hdr.wc} + 17'd2;
    else if (pkt_running && valid_i)
      bytes_left <= bytes_left - 17'(STRB_W);
  end

  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
      beat_o <= '0;
    else if (beat_nxt.valid)
      beat_o <= beat_nxt;
    else
      beat_o <= '0;
  end

endmodule

// ==== source/pkt_fifo.sv ====
`timescale 1ns/10ps
`include "csi2_defs.svh"

module pkt_fifo
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  stream_pkg::beat_t beat_i,
  input  logic              pop_i,
  output stream_pkg::beat_t head_o,
  output logic              pkt_avail_o,
  output logic              ovf_o
);

  localparam int DEPTH  = `CSI2_FIFO_DEPTH;
  localparam int ADDR_W = $clog2(DEPTH);

  stream_pkg::beat_t   mem [DEPTH];
  logic [ADDR_W-1:0]   wr_ptr;
  logic [ADDR_W-1:0]   rd_ptr;
  logic [ADDR_W:0]     fill;
  logic [ADDR_W:0]     last_cnt;
  logic                full;
  logic                empty;
  logic                wr_en;
  logic                rd_en;
  logic                wr_last;
  logic                rd_last;

  assign full    = (fill == (ADDR_W+1)'(DEPTH));
  assign empty   = (fill == '0);
  assign wr_en   = beat_i.valid && !full;
  assign rd_en   = pop_i && !empty;
  assign wr_last = wr_en && beat_i.last;
  assign rd_last = rd_en && mem[rd_ptr].last;

  assign pkt_avail_o = (last_cnt != '0);

  always_comb
  begin
    head_o       = mem[rd_ptr];
    head_o.valid = !empty;
  end

  always_ff @(posedge clk_i)
  begin
    if (wr_en)
      mem[wr_ptr] <= beat_i;
  end

  // pointers wrap on their own, depth is a power of two.
  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill     <= '0;
      last_cnt <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
      fill     <= fill + wr_en - rd_en;
      last_cnt <= last_cnt + wr_last - rd_last;
    end
  end

  // sticky until reset.
  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
      ovf_o <= 1'b0;
    else if (beat_i.valid && full)
      ovf_o <= 1'b1;
  end

endmodule

// ==== source/stream_arbiter.sv ====
`timescale 1ns/10ps

module stream_arbiter
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  stream_pkg::beat_t head0_i,
  input  stream_pkg::beat_t head1_i,
  input  logic              avail0_i,
  input  logic              avail1_i,
  output logic              pop0_o,
  output logic              pop1_o,
  output stream_pkg::beat_t out_o
);

  stream_pkg::arb_state_e state;
  stream_pkg::arb_state_e state_nxt;
  stream_pkg::beat_t      head_sel;
  stream_pkg::beat_t      out_nxt;
  logic                   last_served;
  logic                   serving;
  logic                   sel_port;
  logic                   pkt_done;

  assign pop0_o   = (state == stream_pkg::ARB_SERVE0);
  assign pop1_o   = (state == stream_pkg::ARB_SERVE1);
  assign serving  = pop0_o || pop1_o;
  assign sel_port = pop1_o;
  assign head_sel = pop1_o ? head1_i : head0_i;
  assign pkt_done = serving && head_sel.valid && head_sel.last;

  // round robin, the port not served last wins a tie.
  always_comb
  begin
    state_nxt = state;
    case (state)
      stream_pkg::ARB_IDLE:
        if (avail0_i && avail1_i)
          state_nxt = last_served ? stream_pkg::ARB_SERVE0 : stream_pkg::ARB_SERVE1;
        else if (avail0_i)
          state_nxt = stream_pkg::ARB_SERVE0;
        else if (avail1_i)
          state_nxt = stream_pkg::ARB_SERVE1;
      stream_pkg::ARB_SERVE0, stream_pkg::ARB_SERVE1:
        if (pkt_done)
          state_nxt = stream_pkg::ARB_IDLE;
      default:
        state_nxt = stream_pkg::ARB_IDLE;
    endcase
  end

  always_comb
  begin
    out_nxt       = head_sel;
    out_nxt.valid = serving && head_sel.valid;
    out_nxt.port  = sel_port;
  end

  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
    begin
      state       <= stream_pkg::ARB_IDLE;
      last_served <= 1'b1;
      out_o       <= '0;
    end
    else
    begin
      state <= state_nxt;
      if (pkt_done)
        last_served <= sel_port;
      out_o <= out_nxt.valid ? out_nxt : '0;
    end
  end

endmodule

// ==== source/csi2_rx_top.sv ====
`timescale 1ns/10ps
`include "csi2_defs.svh"

module csi2_rx_top
(
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic [`CSI2_DATA_W-1:0] phy0_data_i,
  input  logic                    phy0_valid_i,
  input  logic                    phy0_err_i,
  input  logic [`CSI2_DATA_W-1:0] phy1_data_i,
  input  logic                    phy1_valid_i,
  input  logic                    phy1_err_i,
  output logic                    phy_rst0_o,
  output logic                    phy_rst1_o,
  output logic                    ovf0_o,
  output logic                    ovf1_o,
  output stream_pkg::beat_t       out_o
);

  stream_pkg::beat_t beat0, beat1;
  stream_pkg::beat_t head0, head1;
  logic              avail0, avail1;
  logic              pop0, pop1;

  csi2_packetizer i_pktz0 (.clk_i(clk_i), .rst_i(rst_i), .data_i(phy0_data_i),
                           .valid_i(phy0_valid_i), .err_i(phy0_err_i),
                           .phy_rst_o(phy_rst0_o), .beat_o(beat0));

  csi2_packetizer i_pktz1 (.clk_i(clk_i), .rst_i(rst_i), .data_i(phy1_data_i),
                           .valid_i(phy1_valid_i), .err_i(phy1_err_i),
                           .phy_rst_o(phy_rst1_o), .beat_o(beat1));

  pkt_fifo i_fifo0 (.clk_i(clk_i), .rst_i(rst_i), .beat_i(beat0), .pop_i(pop0),
                    .head_o(head0), .pkt_avail_o(avail0), .ovf_o(ovf0_o));

  pkt_fifo i_fifo1 (.clk_i(clk_i), .rst_i(rst_i), .beat_i(beat1), .pop_i(pop1),
                    .head_o(head1), .pkt_avail_o(avail1), .ovf_o(ovf1_o));

  // one packet at a time onto the shared output.
  stream_arbiter i_arb (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .head0_i  (head0),
    .head1_i  (head1),
    .avail0_i (avail0),
    .avail1_i (avail1),
    .pop0_o   (pop0),
    .pop1_o   (pop1),
    .out_o    (out_o)
  );

endmodule

// ==== verif/csi2_rx_checker.sv ====
`timescale 1ns/10ps

module csi2_rx_checker
(
  input logic              clk_i,
  input logic              rst_i,
  input stream_pkg::beat_t out_i,
  input logic              phy_rst0_i,
  input logic              phy_rst1_i,
  input logic              ovf0_i,
  input logic              ovf1_i
);

  stream_pkg::beat_t exp0 [$];
  stream_pkg::beat_t exp1 [$];
  // cycle from which each expected packet is complete in its FIFO.
  int                ready0 [$];
  int                ready1 [$];
  string             test_name;
  int                err_cnt;
  int                test_err;
  int                check_cnt;
  int                test_cnt;
  int                cyc;
  int                rst_cnt0;
  int                rst_cnt1;
  bit                ovf_seen0;
  bit                ovf_seen1;
  bit                in_pkt;
  bit                cur_port;
  bit                turn_due;

  function automatic int pending();
    return exp0.size() + exp1.size();
  endfunction

  // a last word on the input raises pkt_avail two cycles later.
  task automatic expect_beat(input stream_pkg::beat_t b);
    if (b.port == 1'b0)
    begin
      exp0.push_back(b);
      if (b.last)
        ready0.push_back(cyc + 3);
    end
    else
    begin
      exp1.push_back(b);
      if (b.last)
        ready1.push_back(cyc + 3);
    end
  endtask

  function automatic bit pkt_waiting(input bit p);
    bit w;
    w = 1'b0;
    if (p == 1'b0 && ready0.size() != 0)
      w = (ready0[0] <= cyc);
    else if (p == 1'b1 && ready1.size() != 0)
      w = (ready1[0] <= cyc);
    return w;
  endfunction

  task automatic retire_packet(input bit p);
    if (p == 1'b0 && ready0.size() != 0)
      ready0.delete(0);
    else if (p == 1'b1 && ready1.size() != 0)
      ready1.delete(0);
  endtask

  task automatic note_error(input string msg);
    $display("%s in test %s", msg, test_name);
    err_cnt++;
    test_err++;
  endtask

  task automatic check_value(input int exp, input int act);
    check_cnt++;
    if (exp != act)
    begin
      $display("Fail %s expected %0d actual %0d", test_name, exp, act);
      err_cnt++;
      test_err++;
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err  = 0;
  endtask

  task automatic end_test();
    test_cnt++;
    $display("test %s finished with %0d errors", test_name, test_err);
  endtask

  task automatic check_rst(input int exp_rst0, input int exp_rst1);
    check_value(exp_rst0, rst_cnt0);
    check_value(exp_rst1, rst_cnt1);
  endtask

  task automatic check_drained();
    if (pending() != 0)
      note_error($sformatf("%0d expected beats never left the DUT", pending()));
    exp0.delete();
    exp1.delete();
    ready0.delete();
    ready1.delete();
  endtask

  task automatic check_beat(input stream_pkg::beat_t b);
    stream_pkg::beat_t e;
    bit                found;
    if (in_pkt && b.port != cur_port)
      note_error("beats of two packets interleaved");
    if (!in_pkt && turn_due && b.port == cur_port)
      note_error("grant did not alternate between waiting ports");
    found = (b.port == 1'b0) ? (exp0.size() != 0) : (exp1.size() != 0);
    if (!found)
      note_error($sformatf("beat from port %0d was never expected", b.port));
    else
    begin
      if (b.port == 1'b0)
        e = exp0.pop_front();
      else
        e = exp1.pop_front();
      check_cnt++;
      if (e !== b)
      begin
        $display("Fail %s expected %h actual %h", test_name, e, b);
        err_cnt++;
        test_err++;
      end
    end
    if (b.last)
      retire_packet(b.port);
    // other port waiting at a packet end is served next.
    turn_due = b.last && pkt_waiting(!b.port);
    in_pkt   = !b.last;
    cur_port = b.port;
  endtask

  always @(negedge clk_i)
  begin
    cyc++;
    if (!rst_i)
    begin
      rst_cnt0 += phy_rst0_i;
      rst_cnt1 += phy_rst1_i;
      if ((ovf_seen0 && !ovf0_i) || (ovf_seen1 && !ovf1_i))
        note_error("an overflow flag fell after it was set");
      ovf_seen0 |= ovf0_i;
      ovf_seen1 |= ovf1_i;
      // data after a dropped beat no longer follows the model.
      if (out_i.valid && !ovf_seen0 && !ovf_seen1)
        check_beat(out_i);
    end
  end

endmodule

// ==== verif/tb_csi2_rx.sv ====
`timescale 1ns/10ps
`include "csi2_defs.svh"

module tb_csi2_rx;

  localparam int N_PKTS = 12 + 12 + 2 * 20 + 2 * 20;
  // longest packet plus widest gap is 32 cycles.
  localparam int MAX_CYCLES = N_PKTS * 32 + 2000;

  logic                    clk_i;
  logic                    rst_i;
  logic [`CSI2_DATA_W-1:0] phy_data [2];
  logic                    phy_valid [2];
  logic                    phy_err [2];
  logic                    phy_rst0;
  logic                    phy_rst1;
  logic                    ovf0;
  logic                    ovf1;
  stream_pkg::beat_t       out_beat;
  int                      rst_exp [2];
  int                      cycle_cnt = 0;

  csi2_rx_top i_dut (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .phy0_data_i  (phy_data[0]),
    .phy0_valid_i (phy_valid[0]),
    .phy0_err_i   (phy_err[0]),
    .phy1_data_i  (phy_data[1]),
    .phy1_valid_i (phy_valid[1]),
    .phy1_err_i   (phy_err[1]),
    .phy_rst0_o   (phy_rst0),
    .phy_rst1_o   (phy_rst1),
    .ovf0_o       (ovf0),
    .ovf1_o       (ovf1),
    .out_o        (out_beat)
  );

  csi2_rx_checker i_chk (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .out_i      (out_beat),
    .phy_rst0_i (phy_rst0),
    .phy_rst1_i (phy_rst1),
    .ovf0_i     (ovf0),
    .ovf1_i     (ovf1)
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES)
    begin
      $display("run stopped after %0d cycles without finishing", cycle_cnt);
      $display("Test failed");
      $finish;
    end
  end

  // mode 0 short, 1 long, 2 mixed with errors, 3 long at full rate.
  task automatic send_packet(input int p, input int mode);
    stream_pkg::beat_t b;
    logic [31:0]       hdr;
    int                wc;
    int                nwords;
    int                err_at;
    int                left;
    int                k;
    bit                is_long;
    is_long   = (mode == 1) || (mode == 3) || (mode == 2 && $urandom_range(1) == 1);
    wc        = (mode == 3) ? 40 : $urandom_range(40, 1);
    hdr       = $urandom;
    hdr[5:0]  = is_long ? 6'h10 + 6'($urandom_range(47)) : 6'($urandom_range(15));
    hdr[23:8] = 16'(wc);
    nwords    = is_long ? (wc + 5) / 4 : 0;
    err_at    = -1;
    if (mode == 2 && is_long && $urandom_range(3) == 0)
      err_at = $urandom_range(nwords - 1);
    b         = '0;
    b.valid   = 1'b1;
    b.data    = hdr;
    b.strb    = '1;
    b.last    = !is_long;
    b.port    = p[0];
    @(posedge clk_i);
    phy_data[p]  <= hdr;
    phy_valid[p] <= 1'b1;
    i_chk.expect_beat(b);
    rst_exp[p] += !is_long;
    for (k = 0; k < nwords; k++)
    begin
      left   = wc + 2 - 4 * k;
      b.data = $urandom;
      b.strb = (left >= 4) ? 4'hf : 4'((1 << left) - 1);
      b.err  = (k == err_at);
      b.last = (k == nwords - 1) || b.err;
      @(posedge clk_i);
      phy_data[p] <= b.data;
      phy_err[p]  <= b.err;
      // words after an error are dropped.
      if (err_at < 0 || k <= err_at)
      begin
        i_chk.expect_beat(b);
        rst_exp[p] += b.last;
      end
    end
    @(posedge clk_i);
    phy_valid[p] <= 1'b0;
    phy_err[p]   <= 1'b0;
    repeat ((mode == 3) ? 0 : $urandom_range(19)) @(posedge clk_i);
  endtask

  task automatic run_phase(input int n, input int mode, input bit [1:0] ports);
    fork
      if (ports[0])
        repeat (n) send_packet(0, mode);
      if (ports[1])
        repeat (n) send_packet(1, mode);
    join
  endtask

  task automatic drain_outputs();
    int wait_cnt;
    for (wait_cnt = 0; wait_cnt < 500 && i_chk.pending() != 0; wait_cnt++)
      @(posedge clk_i);
    repeat (10) @(posedge clk_i);
    i_chk.check_drained();
    i_chk.end_test();
  endtask

  initial
  begin
    void'($urandom(56));
    clk_i = 1'b0;
    rst_i = 1'b1;
    foreach (phy_valid[p])
    begin
      phy_data[p]  = '0;
      phy_valid[p] = 1'b0;
      phy_err[p]   = 1'b0;
      rst_exp[p]   = 0;
    end
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;
    i_chk.start_test("short");
    run_phase(12, 0, 2'b01);
    drain_outputs();
    i_chk.start_test("long");
    run_phase(12, 1, 2'b10);
    drain_outputs();
    i_chk.start_test("mixed");
    run_phase(20, 2, 2'b11);
    drain_outputs();
    i_chk.start_test("phy_rst");
    i_chk.check_rst(rst_exp[0], rst_exp[1]);
    i_chk.end_test();
    // overflow flags are sticky until reset.
    i_chk.start_test("overflow");
    i_chk.check_value(0, ovf0 | ovf1);
    run_phase(20, 3, 2'b11);
    repeat (20) @(posedge clk_i);
    i_chk.check_value(1, ovf0 | ovf1);
    i_chk.end_test();
    $display("%0d tests, %0d checks, %0d errors", i_chk.test_cnt, i_chk.check_cnt,
             i_chk.err_cnt);
    if (i_chk.err_cnt == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+include
source/csi2_pkg.sv
source/stream_pkg.sv
source/csi2_packetizer.sv
source/pkt_fifo.sv
source/stream_arbiter.sv
source/csi2_rx_top.sv
verif/csi2_rx_checker.sv
verif/tb_csi2_rx.sv
